/* list.f */
rtl/pifo_pkg.sv
rtl/rank_compare.sv
rtl/priority_encoder.sv
rtl/pifo_calendar.sv
rtl/pifo_root.sv
verif/pifo_root_tb.sv

/* verif/pifo_stimulus.txt */
# push push_rank push_meta pop | exp_pop_valid exp_pop_rank exp_pop_meta exp_count
# all fields hex; rank and meta are only compared when exp_pop_valid is 1
0 0000 000 1 0 0000 000 00
1 0050 001 0 0 0000 000 01
1 0010 002 0 0 0000 000 02
1 0030 003 0 0 0000 000 03
1 0030 004 0 0 0000 000 04
1 0020 005 0 0 0000 000 05
0 0000 000 1 1 0010 002 04
1 0005 006 1 1 0005 006 04
1 0030 007 1 1 0020 005 04
1 0400 008 0 0 0000 000 05
1 0025 009 0 0 0000 000 06
1 0100 00a 0 0 0000 000 07
1 0060 00b 0 0 0000 000 08
1 ffff 00c 0 0 0000 000 09
1 0001 00d 0 0 0000 000 0a
1 0050 00e 0 0 0000 000 0b
1 0200 00f 0 0 0000 000 0c
1 0075 010 0 0 0000 000 0d
1 0031 011 0 0 0000 000 0e
1 0800 012 0 0 0000 000 0f
1 0090 013 0 0 0000 000 10
1 0000 0ff 0 0 0000 000 10
0 0000 000 1 1 0001 00d 0f
0 0000 000 1 1 0025 009 0e
0 0000 000 1 1 0030 003 0d
0 0000 000 1 1 0030 004 0c
0 0000 000 1 1 0030 007 0b
0 0000 000 1 1 0031 011 0a
0 0000 000 1 1 0050 001 09
0 0000 000 1 1 0050 00e 08
0 0000 000 1 1 0060 00b 07
0 0000 000 1 1 0075 010 06
0 0000 000 1 1 0090 013 05
0 0000 000 1 1 0100 00a 04
0 0000 000 1 1 0200 00f 03
0 0000 000 1 1 0400 008 02
0 0000 000 1 1 0800 012 01
0 0000 000 1 1 ffff 00c 00
0 0000 000 1 0 0000 000 00

/* verif/pifo_root_tb.sv */
`timescale 1ns/1ps

module pifo_root_tb;

    import pifo_pkg::*;

    localparam int clk_period    = 10;
    localparam int reset_cycles  = 16;
    localparam int margin_cycles = 100;
    localparam int max_ops       = 256;

    logic      clk;
    logic      rstn;
    logic      push;
    rank_t     push_rank;
    meta_t     push_meta;
    logic      pop;
    logic      pop_valid;
    rank_t     pop_rank;
    meta_t     pop_meta;
    slot_cnt_t count;
    logic      empty;
    logic      full;

    // operations and expected results for each stimulus line
    logic      op_push   [max_ops];
    rank_t     op_rank   [max_ops];
    meta_t     op_meta   [max_ops];
    logic      op_pop    [max_ops];
    logic      exp_valid [max_ops];
    rank_t     exp_rank  [max_ops];
    meta_t     exp_meta  [max_ops];
    slot_cnt_t exp_count [max_ops];

    int        num_ops;
    int        error_count;
    logic      loaded;

    pifo_root dut0 (
        .clk       (clk),
        .rstn      (rstn),
        .push      (push),
        .push_rank (push_rank),
        .push_meta (push_meta),
        .pop       (pop),
        .pop_valid (pop_valid),
        .pop_rank  (pop_rank),
        .pop_meta  (pop_meta),
        .count     (count),
        .empty     (empty),
        .full      (full)
    );

    always #(clk_period / 2) clk = ~clk;

    ////////////////////////////////////////////////////////////////////////////
    // helpers
    ////////////////////////////////////////////////////////////////////////////

    task automatic load_stimulus();
        int          fd;
        int          n;
        string       line;
        int unsigned f_push, f_rank, f_meta, f_pop;
        int unsigned f_valid, f_erank, f_emeta, f_count;
        fd = $fopen("verif/pifo_stimulus.txt", "r");
        if (fd == 0)
        begin
            $display("could not open the stimulus file verif/pifo_stimulus.txt");
            error_count++;
            return;
        end
        while ($fgets(line, fd) != 0)
        begin
            // skip blank lines and column notes
            if (line.len() < 2 || line[0] == "#")
                continue;
            n = $sscanf(line, "%h %h %h %h %h %h %h %h", f_push, f_rank, f_meta, f_pop,
                        f_valid, f_erank, f_emeta, f_count);
            if (n != 8 || num_ops == max_ops)
            begin
                $display("stimulus line could not be used: %s", line);
                error_count++;
                continue;
            end
            op_push[num_ops]   = f_push[0];
            op_rank[num_ops]   = rank_t'(f_rank);
            op_meta[num_ops]   = meta_t'(f_meta);
            op_pop[num_ops]    = f_pop[0];
            exp_valid[num_ops] = f_valid[0];
            exp_rank[num_ops]  = rank_t'(f_erank);
            exp_meta[num_ops]  = meta_t'(f_emeta);
            exp_count[num_ops] = slot_cnt_t'(f_count);
            num_ops++;
        end
        $fclose(fd);
        if (num_ops == 0)
        begin
            $display("the stimulus file holds no operations");
            error_count++;
        end
    endtask

    task automatic report_mismatch(string name, int unsigned expected, int unsigned actual);
        $display("error at %0d ns: %s expected %0h, got %0h", $time, name, expected, actual);
        error_count++;
    endtask

    // empty and full follow from the expected occupancy
    task automatic compare_outputs(logic ev, rank_t er, meta_t em, slot_cnt_t ec);
        logic ee;
        logic ef;
        ee = (ec == 0);
        ef = (ec == pifo_depth);
        assert (pop_valid === ev) else report_mismatch("pop_valid", ev, pop_valid);
        if (ev)
        begin
            assert (pop_rank === er) else report_mismatch("pop_rank", er, pop_rank);
            assert (pop_meta === em) else report_mismatch("pop_meta", em, pop_meta);
        end
        assert (count === ec) else report_mismatch("count", ec, count);
        assert (empty === ee) else report_mismatch("empty", ee, empty);
        assert (full === ef) else report_mismatch("full", ef, full);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // main sequence
    ////////////////////////////////////////////////////////////////////////////

    initial
    begin
        clk         = 1'b0;
        rstn        = 1'b1;
        push        = 1'b0;
        push_rank   = '0;
        push_meta   = '0;
        pop         = 1'b0;
        num_ops     = 0;
        error_count = 0;
        loaded      = 1'b0;
        load_stimulus();
        loaded = 1'b1;
        repeat (reset_cycles) @(negedge clk);
        rstn = 1'b0;
        compare_outputs(1'b0, '0, '0, '0);
        // each row is checked one falling edge after it was driven
        for (int k = 0; k < num_ops; k++)
        begin
            push      = op_push[k];
            push_rank = op_rank[k];
            push_meta = op_meta[k];
            pop       = op_pop[k];
            @(negedge clk);
            compare_outputs(exp_valid[k], exp_rank[k], exp_meta[k], exp_count[k]);
        end
        push = 1'b0;
        pop  = 1'b0;
        $display("%0d errors over %0d operations", error_count, num_ops);
        if (error_count == 0)
            $display("RESULT: PASS");
        else
            $display("RESULT: FAIL");
        $finish;
    end

    // watchdog sized from the number of stimulus lines
    initial
    begin
        wait (loaded);
        #((num_ops + reset_cycles + margin_cycles) * clk_period);
        $display("timeout: the run did not finish in the expected time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

/* rtl/pifo_root.sv */
`timescale 1ns/1ps

module pifo_root (
    input  logic                clk,
    input  logic                rstn,
    input  logic                push,
    input  pifo_pkg::rank_t     push_rank,
    input  pifo_pkg::meta_t     push_meta,
    input  logic                pop,
    output logic                pop_valid,
    output pifo_pkg::rank_t     pop_rank,
    output pifo_pkg::meta_t     pop_meta,
    output pifo_pkg::slot_cnt_t count,
    output logic                empty,
    output logic                full
);

    import pifo_pkg::*;

    // calendar contents seen by the comparators
    rank_t      slot_rank [pifo_depth];
    slot_mask_t slot_valid;

    // insert position search
    slot_mask_t insert_mask;
    slot_idx_t  insert_idx;
    logic       insert_hit;

    ////////////////////////////////////////////////////////////////////////////
    // sorted storage and output register
    ////////////////////////////////////////////////////////////////////////////

    pifo_calendar u_calendar (
        .clk        (clk),
        .rstn       (rstn),
        .push       (push),
        .push_rank  (push_rank),
        .push_meta  (push_meta),
        .pop        (pop),
        .insert_idx (insert_idx),
        .insert_hit (insert_hit),
        .slot_rank  (slot_rank),
        .slot_valid (slot_valid),
        .pop_valid  (pop_valid),
        .pop_rank   (pop_rank),
        .pop_meta   (pop_meta),
        .count      (count),
        .empty      (empty),
        .full       (full)
    );

    ////////////////////////////////////////////////////////////////////////////
    // insert point, same cycle as the push
    ////////////////////////////////////////////////////////////////////////////

    rank_compare u_rank_compare (
        .push_rank   (push_rank),
        .slot_rank   (slot_rank),
        .slot_valid  (slot_valid),
        .insert_mask (insert_mask)
    );

    priority_encoder u_priority_encoder (
        .insert_mask (insert_mask),
        .insert_idx  (insert_idx),
        .insert_hit  (insert_hit)
    );

endmodule

/* rtl/pifo_calendar.sv */
`timescale 1ns/1ps

module pifo_calendar (
    input  logic                 clk,
    input  logic                 rstn,
    input  logic                 push,
    input  pifo_pkg::rank_t      push_rank,
    input  pifo_pkg::meta_t      push_meta,
    input  logic                 pop,
    input  pifo_pkg::slot_idx_t  insert_idx,
    input  logic                 insert_hit,
    output pifo_pkg::rank_t      slot_rank [pifo_pkg::pifo_depth],
    output pifo_pkg::slot_mask_t slot_valid,
    output logic                 pop_valid,
    output pifo_pkg::rank_t      pop_rank,
    output pifo_pkg::meta_t      pop_meta,
    output pifo_pkg::slot_cnt_t  count,
    output logic                 empty,
    output logic                 full
);

    import pifo_pkg::*;

    meta_t      slot_meta [pifo_depth];

    // next-state of the calendar
    rank_t      rank_nxt [pifo_depth];
    meta_t      meta_nxt [pifo_depth];
    slot_mask_t valid_nxt;
    slot_cnt_t  count_nxt;

    // next-state of the output register
    logic       out_load;
    rank_t      out_rank_nxt;
    meta_t      out_meta_nxt;

    logic       bypass;
    slot_idx_t  merge_idx;

    assign empty = (count == '0);
    assign full  = (count == slot_cnt_t'(pifo_depth));

    // new entry beats the head, or there is no head at all
    assign bypass = empty | (push_rank < slot_rank[0]);

    // on push-with-pop everything moves one toward the head, so the
    // insert point moves too; no hit means the entry goes to the tail
    assign merge_idx = insert_hit ? (insert_idx - slot_idx_t'(1))
                                  : slot_idx_t'(pifo_depth - 1);

    ////////////////////////////////////////////////////////////////////////////
    // operation decode
    ////////////////////////////////////////////////////////////////////////////

    always_comb
    begin
        rank_nxt     = slot_rank;
        meta_nxt     = slot_meta;
        valid_nxt    = slot_valid;
        count_nxt    = count;
        out_load     = 1'b0;
        out_rank_nxt = slot_rank[0];
        out_meta_nxt = slot_meta[0];

        case ({push, pop})
            // push only, dropped when full
            2'b10:
            begin
                if (!full)
                begin
                    for (int i = 1; i < pifo_depth; i++)
                    begin
                        if (i > insert_idx)
                        begin
                            rank_nxt[i]  = slot_rank[i-1];
                            meta_nxt[i]  = slot_meta[i-1];
                            valid_nxt[i] = slot_valid[i-1];
                        end
                    end
                    rank_nxt[insert_idx]  = push_rank;
                    meta_nxt[insert_idx]  = push_meta;
                    valid_nxt[insert_idx] = 1'b1;
                    count_nxt = count + slot_cnt_t'(1);
                end
            end

            // pop only, nothing to return when empty
            2'b01:
            begin
                if (!empty)
                begin
                    out_load = 1'b1;
                    for (int i = 0; i < pifo_depth - 1; i++)
                    begin
                        rank_nxt[i]  = slot_rank[i+1];
                        meta_nxt[i]  = slot_meta[i+1];
                        valid_nxt[i] = slot_valid[i+1];
                    end
                    valid_nxt[pifo_depth-1] = 1'b0;
                    count_nxt = count - slot_cnt_t'(1);
                end
            end

            // push and pop together, occupancy never changes
            2'b11:
            begin
                out_load = 1'b1;
                if (bypass)
                begin
                    out_rank_nxt = push_rank;
                    out_meta_nxt = push_meta;
                end
                else
                begin
                    for (int i = 0; i < pifo_depth - 1; i++)
                    begin
                        if (i < merge_idx)
                        begin
                            rank_nxt[i]  = slot_rank[i+1];
                            meta_nxt[i]  = slot_meta[i+1];
                            valid_nxt[i] = slot_valid[i+1];
                        end
                    end
                    rank_nxt[merge_idx]  = push_rank;
                    meta_nxt[merge_idx]  = push_meta;
                    valid_nxt[merge_idx] = 1'b1;
                end
            end

            default:
            begin
                out_load = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////////
    // registers
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rstn)
        begin
            slot_valid <= '0;
            count      <= '0;
            pop_valid  <= 1'b0;
        end
        else
        begin
            slot_valid <= valid_nxt;
            count      <= count_nxt;
            pop_valid  <= out_load;
        end
    end

    // entry payload, qualified by slot_valid and pop_valid
    always_ff @(posedge clk)
    begin
        slot_rank <= rank_nxt;
        slot_meta <= meta_nxt;
        if (out_load)
        begin
            pop_rank <= out_rank_nxt;
            pop_meta <= out_meta_nxt;
        end
    end

endmodule

/* rtl/priority_encoder.sv */
`timescale 1ns/1ps

module priority_encoder (
    input  pifo_pkg::slot_mask_t insert_mask,
    output pifo_pkg::slot_idx_t  insert_idx,
    output logic                 insert_hit
);

    import pifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // lowest set bit
    ////////////////////////////////////////////////////////////////////////////

    // scan from the head and latch the first hit
    always_comb
    begin
        insert_idx = '0;
        insert_hit = 1'b0;

        for (int j = 0; j < pifo_depth; j++)
        begin
            if (insert_mask[j] && !insert_hit)
            begin
                insert_idx = slot_idx_t'(j);
                insert_hit = 1'b1;
            end
        end
    end

    // no hit only when every slot is valid and ranks at or
    // before the new entry, i.e. a full calendar with a tail push

endmodule

/* rtl/rank_compare.sv */
`timescale 1ns/1ps

module rank_compare (
    input  pifo_pkg::rank_t      push_rank,
    input  pifo_pkg::rank_t      slot_rank [pifo_pkg::pifo_depth],
    input  pifo_pkg::slot_mask_t slot_valid,
    output pifo_pkg::slot_mask_t insert_mask
);

    import pifo_pkg::*;

    ////////////////////////////////////////////////////////////////////////////
    // comparator array
    ////////////////////////////////////////////////////////////////////////////

    // one comparator per slot, all in parallel
    // a free slot always accepts the new entry
    // strict less-than keeps equal ranks in arrival order
    genvar j;

    generate
        for (j = 0; j < pifo_depth; j++)
        begin : g_cmp
            logic slot_free;
            logic rank_before;

            assign slot_free   = ~slot_valid[j];
            assign rank_before = (push_rank < slot_rank[j]);

            assign insert_mask[j] = slot_free | rank_before;
        end
    endgenerate

    // the calendar stays packed toward the head, so the mask is
    // a run of zeros followed by a run of ones; the encoder only
    // needs the first one

endmodule

/* rtl/pifo_pkg.sv */
package pifo_pkg;

    ////////////////////////////////////////////////////////////////////////////
    // calendar geometry
    ////////////////////////////////////////////////////////////////////////////

    // number of sorted slots in the root calendar
    localparam int pifo_depth = 16;

    // slot address and occupancy widths
    localparam int idx_w = 4;
    localparam int cnt_w = 5;

    ////////////////////////////////////////////////////////////////////////////
    // entry fields
    ////////////////////////////////////////////////////////////////////////////

    localparam int rank_w = 16;
    localparam int meta_w = 12;

    // smaller rank is served first
    typedef logic [rank_w-1:0] rank_t;

    // opaque flow metadata, carried along with the rank
    typedef logic [meta_w-1:0] meta_t;

    // slot position, 0 is the head
    typedef logic [idx_w-1:0] slot_idx_t;

    // occupancy, 0 up to pifo_depth
    typedef logic [cnt_w-1:0] slot_cnt_t;

    // one bit per slot
    typedef logic [pifo_depth-1:0] slot_mask_t;

endpackage
